// ==== design/exec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  wire exec_pkg::exec_op_e opcode_i,
    input  wire exec_pkg::xlen_t    pc_i,
    input  wire exec_pkg::xlen_t    op1_i,
    input  wire exec_pkg::xlen_t    op2_i,
    input  wire exec_pkg::xlen_t    imm_i,
    output logic                    redirect_o,
    output exec_pkg::xlen_t         result_o,
    output exec_pkg::xlen_t         target_o,
    output exec_pkg::xlen_t         mem_addr_o
);

    import exec_pkg::*;

    function automatic xlen_t sext32(input logic [31:0] value);
        return {{32{value[31]}}, value};
    endfunction

    xlen_t       sum;
    xlen_t       diff;
    xlen_t       upper_imm;
    xlen_t       op1_plus_imm;
    xlen_t       pc_plus_imm;
    xlen_t       link_addr;
    logic [31:0] sllw_res;
    logic [31:0] srlw_res;
    logic [31:0] sraw_res;
    logic        lt_signed;
    logic        lt_unsigned;
    logic        equal;

    assign sum          = op1_i + op2_i;
    assign diff         = op1_i - op2_i;
    assign op1_plus_imm = op1_i + imm_i;
    assign pc_plus_imm  = pc_i + imm_i;
    assign link_addr    = pc_i + 64'd4;

    // 20-bit upper immediate placed at bit 12
    assign upper_imm = {{32{op2_i[19]}}, op2_i[19:0], 12'h000};

    // word shifts use only the low five shift bits
    assign sllw_res = op1_i[31:0] << op2_i[4:0];
    assign srlw_res = op1_i[31:0] >> op2_i[4:0];
    assign sraw_res = $signed(op1_i[31:0]) >>> op2_i[4:0];

    assign lt_signed   = $signed(op1_i) < $signed(op2_i);
    assign lt_unsigned = op1_i < op2_i;
    assign equal       = op1_i == op2_i;

    always_comb begin
        case (opcode_i)
            OP_ADD:   result_o = sum;
            OP_SUB:   result_o = diff;
            OP_SLT:   result_o = {63'd0, lt_signed};
            OP_SLTU:  result_o = {63'd0, lt_unsigned};
            OP_XOR:   result_o = op1_i ^ op2_i;
            OP_OR:    result_o = op1_i | op2_i;
            OP_AND:   result_o = op1_i & op2_i;
            OP_SLL:   result_o = op1_i << op2_i[5:0];
            OP_SRL:   result_o = op1_i >> op2_i[5:0];
            OP_SRA:   result_o = $signed(op1_i) >>> op2_i[5:0];
            OP_ADDW:  result_o = sext32(sum[31:0]);
            OP_SUBW:  result_o = sext32(diff[31:0]);
            OP_SLLW:  result_o = sext32(sllw_res);
            OP_SRLW:  result_o = sext32(srlw_res);
            OP_SRAW:  result_o = sext32(sraw_res);
            OP_LUI:   result_o = upper_imm;
            OP_AUIPC: result_o = pc_i + upper_imm;
            OP_JAL,
            OP_JALR:  result_o = link_addr;
            default:  result_o = '0;
        endcase
    end

    // jumps always redirect
    always_comb begin
        case (opcode_i)
            OP_BEQ:  redirect_o = equal;
            OP_BNE:  redirect_o = !equal;
            OP_BLT:  redirect_o = lt_signed;
            OP_BGE:  redirect_o = !lt_signed;
            OP_BLTU: redirect_o = lt_unsigned;
            OP_BGEU: redirect_o = !lt_unsigned;
            OP_JAL,
            OP_JALR: redirect_o = 1'b1;
            default: redirect_o = 1'b0;
        endcase
    end

    assign target_o = (opcode_i == OP_JALR) ? {op1_plus_imm[63:1], 1'b0} : pc_plus_imm;

    // only meaningful for loads and stores
    assign mem_addr_o = op1_plus_imm;

endmodule

`default_nettype wire

// ==== design/exec_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_commit (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      valid_i,
    input  wire exec_pkg::exec_op_e  opcode_i,
    input  wire                      rd_en_i,
    input  wire exec_pkg::reg_addr_t rd_addr_i,
    input  wire exec_pkg::xlen_t     alu_result_i,
    input  wire exec_pkg::xlen_t     alu_target_i,
    input  wire exec_pkg::xlen_t     mem_addr_i,
    input  wire exec_pkg::xlen_t     csr_rdata_i,
    input  wire exec_pkg::xlen_t     trap_target_i,
    input  wire                      alu_redirect_i,
    input  wire                      trap_redirect_i,
    input  wire                      trap_taken_i,
    output logic                     valid_o,
    output logic                     rd_en_o,
    output logic                     redirect_o,
    output exec_pkg::reg_addr_t      rd_addr_o,
    output exec_pkg::xlen_t          rd_data_o,
    output exec_pkg::xlen_t          redirect_pc_o,
    output exec_pkg::xlen_t          mem_addr_o
);

    import exec_pkg::*;

    logic  is_csr_op;
    logic  wb_en;
    xlen_t wb_data;

    assign is_csr_op = (opcode_i == OP_CSRRW) || (opcode_i == OP_CSRRS) ||
                       (opcode_i == OP_CSRRC);
    assign wb_data   = is_csr_op ? csr_rdata_i : alu_result_i;

    // x0 is never written, and a taken trap drops the write
    assign wb_en = valid_i && rd_en_i && (rd_addr_i != '0) && !trap_taken_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o    <= 1'b0;
            rd_en_o    <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            valid_o    <= valid_i;
            rd_en_o    <= wb_en;
            redirect_o <= valid_i && (trap_redirect_i || alu_redirect_i);
        end
    end

    // trap and mret redirects win over branches
    always_ff @(posedge clk) begin
        rd_addr_o     <= rd_addr_i;
        rd_data_o     <= wb_data;
        redirect_pc_o <= trap_redirect_i ? trap_target_i : alu_target_i;
        mem_addr_o    <= mem_addr_i;
    end

    a_redirect_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i) redirect_o |-> valid_o
    );

endmodule

`default_nettype wire

// ==== design/exec_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_csr #(
    parameter exec_pkg::xlen_t RESET_MTVEC = 64'h8000_0100
) (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      valid_i,
    input  wire                      timer_irq_i,
    input  wire exec_pkg::exec_op_e  opcode_i,
    input  wire exec_pkg::xlen_t     pc_i,
    input  wire exec_pkg::xlen_t     op1_i,
    input  wire exec_pkg::csr_addr_t csr_addr_i,
    output exec_pkg::xlen_t          rdata_o,
    output exec_pkg::xlen_t          trap_target_o,
    output logic                     trap_redirect_o,
    output logic                     trap_taken_o
);

    import exec_pkg::*;

    logic  mie_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;

    xlen_t mstatus_val;
    xlen_t csr_old;
    xlen_t csr_wdata;
    logic  csr_we;
    logic  timer_trap;
    logic  ecall_hit;
    logic  mret_hit;

    // a pending timer interrupt replaces the instruction
    assign timer_trap = valid_i && timer_irq_i && mie_q;
    assign ecall_hit  = valid_i && !timer_trap && (opcode_i == OP_ECALL);
    assign mret_hit   = valid_i && !timer_trap && (opcode_i == OP_MRET);

    always_comb begin
        mstatus_val = '0;
        mstatus_val[MSTATUS_MIE_BIT] = mie_q;
    end

    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS: csr_old = mstatus_val;
            CSR_MTVEC:   csr_old = mtvec_q;
            CSR_MEPC:    csr_old = mepc_q;
            CSR_MCAUSE:  csr_old = mcause_q;
            default:     csr_old = '0;
        endcase
    end

    // set and clear skip the write for a zero mask
    always_comb begin
        csr_wdata = op1_i;
        csr_we    = 1'b0;
        case (opcode_i)
            OP_CSRRW: begin
                csr_wdata = op1_i;
                csr_we    = 1'b1;
            end
            OP_CSRRS: begin
                csr_wdata = csr_old | op1_i;
                csr_we    = op1_i != '0;
            end
            OP_CSRRC: begin
                csr_wdata = csr_old & ~op1_i;
                csr_we    = op1_i != '0;
            end
            default: begin
                csr_we = 1'b0;
            end
        endcase
        csr_we = csr_we && valid_i && !timer_trap;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mie_q    <= 1'b0;
            mtvec_q  <= RESET_MTVEC;
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (timer_trap || ecall_hit) begin
            mepc_q   <= pc_i;
            mcause_q <= timer_trap ? CAUSE_TIMER_M : CAUSE_ECALL_M;
            mie_q    <= 1'b0;
        end else if (mret_hit) begin
            mie_q <= 1'b1;
        end else if (csr_we) begin
            case (csr_addr_i)
                CSR_MSTATUS: mie_q    <= csr_wdata[MSTATUS_MIE_BIT];
                CSR_MTVEC:   mtvec_q  <= {csr_wdata[63:2], 2'b00};
                CSR_MEPC:    mepc_q   <= {csr_wdata[63:1], 1'b0};
                CSR_MCAUSE:  mcause_q <= csr_wdata;
                default:     mcause_q <= mcause_q;
            endcase
        end
    end

    assign rdata_o         = csr_old;
    assign trap_redirect_o = timer_trap || ecall_hit || mret_hit;
    assign trap_target_o   = mret_hit ? mepc_q : mtvec_q;
    assign trap_taken_o    = timer_trap;

    a_redirect_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i) trap_redirect_o |-> valid_i
    );

    // vector stays word aligned across resets and writes
    a_mtvec_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i) mtvec_q[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== design/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    // immediate forms reuse the register opcodes
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADDW,
        OP_SUBW,
        OP_SLLW,
        OP_SRLW,
        OP_SRAW,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LOAD,
        OP_STORE,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ECALL,
        OP_MRET
    } exec_op_e;

    // machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // trap causes
    localparam xlen_t CAUSE_ECALL_M = 64'd11;
    localparam xlen_t CAUSE_TIMER_M = 64'h8000_0000_0000_0007;

    localparam int MSTATUS_MIE_BIT = 3;

endpackage

`default_nettype wire

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter exec_pkg::xlen_t RESET_MTVEC = 64'h8000_0100
) (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      valid_i,
    input  wire                      rd_en_i,
    input  wire                      timer_irq_i,
    input  wire exec_pkg::exec_op_e  opcode_i,
    input  wire exec_pkg::xlen_t     pc_i,
    input  wire exec_pkg::xlen_t     op1_i,
    input  wire exec_pkg::xlen_t     op2_i,
    input  wire exec_pkg::xlen_t     imm_i,
    input  wire exec_pkg::reg_addr_t rd_addr_i,
    input  wire exec_pkg::csr_addr_t csr_addr_i,
    output logic                     valid_o,
    output logic                     rd_en_o,
    output logic                     redirect_o,
    output exec_pkg::reg_addr_t      rd_addr_o,
    output exec_pkg::xlen_t          rd_data_o,
    output exec_pkg::xlen_t          redirect_pc_o,
    output exec_pkg::xlen_t          mem_addr_o
);

    import exec_pkg::*;

    xlen_t alu_result;
    xlen_t alu_target;
    xlen_t mem_addr;
    xlen_t csr_rdata;
    xlen_t trap_target;
    logic  alu_redirect;
    logic  trap_redirect;
    logic  trap_taken;

    exec_alu exec_alu_i (
        .opcode_i   (opcode_i),
        .pc_i       (pc_i),
        .op1_i      (op1_i),
        .op2_i      (op2_i),
        .imm_i      (imm_i),
        .redirect_o (alu_redirect),
        .result_o   (alu_result),
        .target_o   (alu_target),
        .mem_addr_o (mem_addr)
    );

    exec_csr #(
        .RESET_MTVEC (RESET_MTVEC)
    ) exec_csr_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .valid_i         (valid_i),
        .timer_irq_i     (timer_irq_i),
        .opcode_i        (opcode_i),
        .pc_i            (pc_i),
        .op1_i           (op1_i),
        .csr_addr_i      (csr_addr_i),
        .rdata_o         (csr_rdata),
        .trap_target_o   (trap_target),
        .trap_redirect_o (trap_redirect),
        .trap_taken_o    (trap_taken)
    );

    exec_commit exec_commit_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .valid_i         (valid_i),
        .opcode_i        (opcode_i),
        .rd_en_i         (rd_en_i),
        .rd_addr_i       (rd_addr_i),
        .alu_result_i    (alu_result),
        .alu_target_i    (alu_target),
        .mem_addr_i      (mem_addr),
        .csr_rdata_i     (csr_rdata),
        .trap_target_i   (trap_target),
        .alu_redirect_i  (alu_redirect),
        .trap_redirect_i (trap_redirect),
        .trap_taken_i    (trap_taken),
        .valid_o         (valid_o),
        .rd_en_o         (rd_en_o),
        .redirect_o      (redirect_o),
        .rd_addr_o       (rd_addr_o),
        .rd_data_o       (rd_data_o),
        .redirect_pc_o   (redirect_pc_o),
        .mem_addr_o      (mem_addr_o)
    );

endmodule

`default_nettype wire

// ==== exec_unit.f ====
design/exec_pkg.sv
design/exec_alu.sv
design/exec_csr.sv
design/exec_commit.sv
design/exec_unit.sv
tests/exec_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the exec_unit testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module exec_unit_tb -f exec_unit.f \
    -o exec_unit_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/exec_unit_sim > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

// ==== tests/exec_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;

    import exec_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 5;
    localparam int CYCLES_PER_LINE = 50;

    typedef struct {
        int        src_line;
        exec_op_e  opcode;
        xlen_t     pc;
        xlen_t     op1;
        xlen_t     op2;
        xlen_t     imm;
        logic      rd_en;
        reg_addr_t rd_addr;
        csr_addr_t csr_addr;
        logic      timer_irq;
        logic      exp_rd_en;
        xlen_t     exp_rd_data;
        logic      exp_redirect;
        xlen_t     exp_redirect_pc;
        xlen_t     exp_mem_addr;
    } test_line_t;

    logic      clk;
    logic      rst_n_i;
    logic      valid_i;
    logic      rd_en_i;
    logic      timer_irq_i;
    exec_op_e  opcode_i;
    xlen_t     pc_i;
    xlen_t     op1_i;
    xlen_t     op2_i;
    xlen_t     imm_i;
    reg_addr_t rd_addr_i;
    csr_addr_t csr_addr_i;
    logic      valid_o;
    logic      rd_en_o;
    logic      redirect_o;
    reg_addr_t rd_addr_o;
    xlen_t     rd_data_o;
    xlen_t     redirect_pc_o;
    xlen_t     mem_addr_o;

    test_line_t tests[$];
    int         cur_line = 0;
    logic       tests_loaded = 1'b0;

    exec_unit #(
        .RESET_MTVEC (64'h8000_0100)
    ) exec_unit_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .rd_en_i       (rd_en_i),
        .timer_irq_i   (timer_irq_i),
        .opcode_i      (opcode_i),
        .pc_i          (pc_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .imm_i         (imm_i),
        .rd_addr_i     (rd_addr_i),
        .csr_addr_i    (csr_addr_i),
        .valid_o       (valid_o),
        .rd_en_o       (rd_en_o),
        .redirect_o    (redirect_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o),
        .redirect_pc_o (redirect_pc_o),
        .mem_addr_o    (mem_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (line %0d)", name, got, exp, cur_line);
            abort_run();
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (line %0d)", name, got, exp, cur_line);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (line %0d)", name, got, exp, cur_line);
            abort_run();
        end
    endtask

    // comment and blank lines are skipped
    task automatic load_tests();
        int         fd;
        int         line_no;
        int         op_num;
        int         count;
        string      text;
        test_line_t t;
        line_no = 0;
        fd = $fopen("tests/exec_unit_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/exec_unit_tests.txt");
            abort_run();
        end else begin
            while ($fgets(text, fd) != 0) begin
                line_no++;
                if (text.len() < 2 || text.substr(0, 0) == "#") continue;
                count = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                op_num, t.pc, t.op1, t.op2, t.imm, t.rd_en, t.rd_addr,
                                t.csr_addr, t.timer_irq, t.exp_rd_en, t.exp_rd_data,
                                t.exp_redirect, t.exp_redirect_pc, t.exp_mem_addr);
                if (count != 14) begin
                    $display("line %0d of the stimulus file is malformed", line_no);
                    abort_run();
                end else begin
                    t.src_line = line_no;
                    t.opcode   = exec_op_e'(op_num[5:0]);
                    tests.push_back(t);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input test_line_t t);
        valid_i     = 1'b1;
        opcode_i    = t.opcode;
        pc_i        = t.pc;
        op1_i       = t.op1;
        op2_i       = t.op2;
        imm_i       = t.imm;
        rd_en_i     = t.rd_en;
        rd_addr_i   = t.rd_addr;
        csr_addr_i  = t.csr_addr;
        timer_irq_i = t.timer_irq;
    endtask

    // fields that do not apply to an instruction are left unchecked
    task automatic check_result(input test_line_t t);
        cur_line = t.src_line;
        if (valid_o !== 1'b1) begin
            $display("valid_o did not arrive one cycle after the instruction on line %0d",
                     t.src_line);
            abort_run();
        end else begin
            check_flag("rd_en_o", rd_en_o, t.exp_rd_en);
            check_reg_addr("rd_addr_o", rd_addr_o, t.rd_addr);
            if (t.exp_rd_en) check_word("rd_data_o", rd_data_o, t.exp_rd_data);
            check_flag("redirect_o", redirect_o, t.exp_redirect);
            if (t.exp_redirect) check_word("redirect_pc_o", redirect_pc_o, t.exp_redirect_pc);
            if (t.opcode == OP_LOAD || t.opcode == OP_STORE) begin
                check_word("mem_addr_o", mem_addr_o, t.exp_mem_addr);
            end
        end
    endtask

    initial begin
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        rd_en_i     = 1'b0;
        timer_irq_i = 1'b0;
        opcode_i    = OP_NOP;
        pc_i        = '0;
        op1_i       = '0;
        op2_i       = '0;
        imm_i       = '0;
        rd_addr_i   = '0;
        csr_addr_i  = '0;
        load_tests();
        if (tests.size() == 0) begin
            $display("the stimulus file holds no instructions");
            abort_run();
        end
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        check_flag("valid_o", valid_o, 1'b0);
        check_flag("rd_en_o", rd_en_o, 1'b0);
        check_flag("redirect_o", redirect_o, 1'b0);
        // one instruction per cycle, back to back
        foreach (tests[i]) begin
            apply_line(tests[i]);
            @(negedge clk);
            check_result(tests[i]);
        end
        valid_i = 1'b0;
        @(negedge clk);
        check_flag("valid_o", valid_o, 1'b0);
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        wait (tests_loaded === 1'b1);
        #((tests.size() * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before all results were checked");
        abort_run();
    end

endmodule

`default_nettype wire

// ==== tests/exec_unit_tests.txt ====
# op(dec) pc op1 op2 imm rd_en rd_addr csr_addr timer_irq, then expected rd_en rd_data redirect redirect_pc mem_addr
# all but op in hex; expected rd_data, redirect_pc and mem_addr are 0 where they do not apply
1 1000 5 7 0 1 1 0 0 1 c 0 0 0
2 1004 5 7 0 1 2 0 0 1 fffffffffffffffe 0 0 0
3 1008 fffffffffffffffe 1 0 1 3 0 0 1 1 0 0 0
4 100c fffffffffffffffe 1 0 1 4 0 0 1 0 0 0 0
5 1010 ff00ff00 ff00ff0 0 1 5 0 0 1 f0f0f0f0 0 0 0
6 1014 ff00ff00 ff00ff0 0 1 6 0 0 1 fff0fff0 0 0 0
7 1018 ff00ff00 ff00ff0 0 1 7 0 0 1 f000f00 0 0 0
8 101c 1 3f 0 1 8 0 0 1 8000000000000000 0 0 0
10 1020 8000000000000000 4 0 1 9 0 0 1 f800000000000000 0 0 0
12 1024 100000005 7 0 1 a 0 0 1 fffffffffffffffe 0 0 0
13 1028 1 1f 0 1 b 0 0 1 ffffffff80000000 0 0 0
15 102c 80000000 4 0 1 c 0 0 1 fffffffff8000000 0 0 0
16 1030 0 80000 0 1 d 0 0 1 ffffffff80000000 0 0 0
17 2000 0 1 0 1 e 0 0 1 3000 0 0 0
18 3000 0 0 100 1 1 0 0 1 3004 1 3100 0
19 3100 4001 0 10 1 1 0 0 1 3104 1 4010 0
20 4000 5 5 40 0 0 0 0 0 0 1 4040 0
21 4000 5 6 fffffffffffffff0 0 0 0 0 0 0 1 3ff0 0
22 4000 ffffffffffffffff 1 8 0 0 0 0 0 0 1 4008 0
23 4000 ffffffffffffffff 1 8 0 0 0 0 0 0 0 0 0
25 4000 ffffffffffffffff 1 20 0 0 0 0 0 0 1 4020 0
26 4100 10000 0 fffffffffffffff8 0 5 0 0 0 0 0 0 fff8
27 4104 20000 0 18 0 0 0 0 0 0 0 0 20018
1 4108 1 2 0 1 0 0 0 0 0 0 0 0
28 4200 80000200 0 0 1 6 305 0 1 80000100 0 0 0
29 4204 0 0 0 1 7 305 0 1 80000200 0 0 0
30 4208 200 0 0 1 8 305 0 1 80000200 0 0 0
29 420c 0 0 0 1 9 305 0 1 80000000 0 0 0
31 5000 0 0 0 0 0 0 0 0 0 1 80000000 0
29 80000000 0 0 0 1 a 342 0 1 b 0 0 0
29 80000004 0 0 0 1 b 341 0 1 5000 0 0 0
32 80000008 0 0 0 0 0 0 0 0 0 1 5000 0
30 5004 8 0 0 1 c 300 0 1 8 0 0 0
1 5008 3 4 0 1 d 0 1 1 7 0 0 0
29 500c 8 0 0 1 e 300 0 1 0 0 0 0
1 5010 3 4 0 1 d 0 1 0 0 1 80000000 0
29 80000000 0 0 0 1 f 342 0 1 8000000000000007 0 0 0
29 80000004 0 0 0 1 10 341 0 1 5010 0 0 0
